// ==== logic/core_config.svh ====
// Core configuration for the integer pipeline widths and register count
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Register index width
`define CORE_ADDR_WIDTH 5
// Register data width
`define CORE_DATA_WIDTH 32
// Immediate field width, sign-extended to a full word
`define CORE_IMM_WIDTH 12
// Register count including the hardwired zero register
`define CORE_NUM_REGS 32

`endif

// ==== logic/core_pkg.sv ====
// Core package with width types, opcodes and pipeline entry structs
`include "core_config.svh"

package core_pkg;

  // --------------------
  // Width types
  // --------------------
  typedef logic [`CORE_ADDR_WIDTH-1:0]       reg_addr_t;
  typedef logic [`CORE_DATA_WIDTH-1:0]       word_t;
  typedef logic signed [`CORE_IMM_WIDTH-1:0] imm_t;

  // Operation encoding
  typedef enum logic [2:0] {
    OP_LI,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_MAC,
    OP_PINC
  } op_e;

  // --------------------
  // Pipeline structs
  // --------------------
  // Instruction word as it arrives at the top
  typedef struct packed {
    logic      valid;
    op_e       op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rs3;
    imm_t      imm;
  } instr_t;

  // Execute entry with resolved operands
  typedef struct packed {
    logic      valid;
    op_e       op;
    reg_addr_t rd;
    reg_addr_t rs1;
    word_t     src1;
    word_t     src2;
    word_t     src3;
    word_t     imm;
  } ex_entry_t;

  // Both register file write ports
  typedef struct packed {
    logic      we_a;
    reg_addr_t waddr_a;
    word_t     wdata_a;
    logic      we_b;
    reg_addr_t waddr_b;
    word_t     wdata_b;
  } wb_entry_t;

endpackage

// ==== logic/exec_stage.sv ====
// Execute stage computing up to two results and holding the writeback register
module exec_stage (
  input  logic                clk,
  input  logic                rst_n,

  // Entry from the operand stage
  input  core_pkg::ex_entry_t ex_i,

  // Combinational results for forwarding
  output core_pkg::wb_entry_t ex_fwd_o,

  // Writeback register, drives the write ports
  output core_pkg::wb_entry_t wb_o
);

  import core_pkg::*;

  // Datapath intermediates
  word_t     mac_prod;
  word_t     pinc_sum;
  word_t     result_a;

  // Writeback register split into enables and payload
  wb_entry_t data_q;
  logic      we_a_q;
  logic      we_b_q;

  // --------------------
  // Datapath
  // --------------------
  // Low word of the 32x32 product
  assign mac_prod = ex_i.src1 * ex_i.src2;

  // Post-increment of source 1
  assign pinc_sum = ex_i.src1 + ex_i.imm;

  // Port A result per operation
  always_comb begin
    case (ex_i.op)
      OP_LI:   result_a = ex_i.imm;
      OP_ADD:  result_a = ex_i.src1 + ex_i.src2;
      OP_SUB:  result_a = ex_i.src1 - ex_i.src2;
      OP_AND:  result_a = ex_i.src1 & ex_i.src2;
      OP_OR:   result_a = ex_i.src1 | ex_i.src2;
      OP_XOR:  result_a = ex_i.src1 ^ ex_i.src2;
      OP_MAC:  result_a = mac_prod + ex_i.src3;
      // Old value of source 1 goes to rd
      OP_PINC: result_a = ex_i.src1;
      default: result_a = '0;
    endcase
  end

  // --------------------
  // Write ports
  // --------------------
  always_comb begin
    ex_fwd_o.we_a    = ex_i.valid;
    ex_fwd_o.waddr_a = ex_i.rd;
    ex_fwd_o.wdata_a = result_a;
    // Second write only for post-increment, back to rs1
    ex_fwd_o.we_b    = ex_i.valid && (ex_i.op == OP_PINC);
    ex_fwd_o.waddr_b = ex_i.rs1;
    ex_fwd_o.wdata_b = pinc_sum;
  end

  // Enables cleared on reset and on bubbles
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_a_q <= 1'b0;
      we_b_q <= 1'b0;
    end else begin
      we_a_q <= ex_fwd_o.we_a;
      we_b_q <= ex_fwd_o.we_b;
    end
  end

  // Addresses and data follow valid entries only
  always_ff @(posedge clk) begin
    if (ex_i.valid) begin
      data_q <= ex_fwd_o;
    end
  end

  always_comb begin
    wb_o      = data_q;
    wb_o.we_a = we_a_q;
    wb_o.we_b = we_b_q;
  end

endmodule

// ==== logic/int_pipeline.sv ====
// Three-stage integer pipeline top with forwarding and a commit trace
module int_pipeline (
  input  logic                clk,
  input  logic                rst_n,

  // Instruction strobe and word
  input  core_pkg::instr_t    instr_i,

  // Writeback register, two cycles after acceptance
  output core_pkg::wb_entry_t commit_o
);

  import core_pkg::*;

  // Read path between operand stage and register file
  reg_addr_t raddr_a;
  reg_addr_t raddr_b;
  reg_addr_t raddr_c;
  word_t     rdata_a;
  word_t     rdata_b;
  word_t     rdata_c;

  // Stage to stage
  ex_entry_t ex_entry;
  wb_entry_t ex_fwd;
  wb_entry_t wb;

  // --------------------
  // Operand stage
  // --------------------
  operand_stage u_operand_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .instr_i   (instr_i),
    .raddr_a_o (raddr_a),
    .raddr_b_o (raddr_b),
    .raddr_c_o (raddr_c),
    .rdata_a_i (rdata_a),
    .rdata_b_i (rdata_b),
    .rdata_c_i (rdata_c),
    .ex_fwd_i  (ex_fwd),
    .wb_i      (wb),
    .ex_o      (ex_entry)
  );

  // --------------------
  // Execute stage
  // --------------------
  exec_stage u_exec_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .ex_i     (ex_entry),
    .ex_fwd_o (ex_fwd),
    .wb_o     (wb)
  );

  // Register file, written from the writeback register
  reg_file u_reg_file (
    .clk       (clk),
    .rst_n     (rst_n),
    .raddr_a_i (raddr_a),
    .rdata_a_o (rdata_a),
    .raddr_b_i (raddr_b),
    .rdata_b_o (rdata_b),
    .raddr_c_i (raddr_c),
    .rdata_c_o (rdata_c),
    .wb_i      (wb)
  );

  // Commit trace
  assign commit_o = wb;

endmodule

// ==== logic/operand_stage.sv ====
// Operand stage resolving three sources through forwarding into the execute entry
`include "core_config.svh"

module operand_stage (
  input  logic                clk,
  input  logic                rst_n,

  // Incoming instruction, sampled every edge
  input  core_pkg::instr_t    instr_i,

  // Register file read addresses
  output core_pkg::reg_addr_t raddr_a_o,
  output core_pkg::reg_addr_t raddr_b_o,
  output core_pkg::reg_addr_t raddr_c_o,

  // Register file read data
  input  core_pkg::word_t     rdata_a_i,
  input  core_pkg::word_t     rdata_b_i,
  input  core_pkg::word_t     rdata_c_i,

  // Forwarding sources, youngest first
  input  core_pkg::wb_entry_t ex_fwd_i,
  input  core_pkg::wb_entry_t wb_i,

  // Registered entry for the execute stage
  output core_pkg::ex_entry_t ex_o
);

  import core_pkg::*;

  // Next entry and its payload register
  ex_entry_t ex_d;
  ex_entry_t payload_q;
  logic      valid_q;

  // Pick the newest value of a source register
  // Order is execute B, execute A, writeback B, writeback A, then the file
  function automatic word_t resolve(input reg_addr_t addr, input word_t rf_data,
                                    input wb_entry_t ex_fwd, input wb_entry_t wb);
    word_t data;
    if (addr == '0) begin
      data = '0;
    end else if (ex_fwd.we_b && ex_fwd.waddr_b == addr) begin
      data = ex_fwd.wdata_b;
    end else if (ex_fwd.we_a && ex_fwd.waddr_a == addr) begin
      data = ex_fwd.wdata_a;
    end else if (wb.we_b && wb.waddr_b == addr) begin
      data = wb.wdata_b;
    end else if (wb.we_a && wb.waddr_a == addr) begin
      data = wb.wdata_a;
    end else begin
      data = rf_data;
    end
    return data;
  endfunction

  // --------------------
  // Register file reads
  // --------------------
  assign raddr_a_o = instr_i.rs1;
  assign raddr_b_o = instr_i.rs2;
  assign raddr_c_o = instr_i.rs3;

  // Build the next execute entry
  always_comb begin
    ex_d       = '0;
    ex_d.valid = instr_i.valid;
    ex_d.op    = instr_i.op;
    ex_d.rd    = instr_i.rd;
    ex_d.rs1   = instr_i.rs1;
    ex_d.src1  = resolve(instr_i.rs1, rdata_a_i, ex_fwd_i, wb_i);
    ex_d.src2  = resolve(instr_i.rs2, rdata_b_i, ex_fwd_i, wb_i);
    ex_d.src3  = resolve(instr_i.rs3, rdata_c_i, ex_fwd_i, wb_i);
    // Sign extension of the immediate
    ex_d.imm   = {{(`CORE_DATA_WIDTH-`CORE_IMM_WIDTH){instr_i.imm[`CORE_IMM_WIDTH-1]}},
                  instr_i.imm};
  end

  // --------------------
  // Execute entry
  // --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= instr_i.valid;
    end
  end

  // Payload only moves with a valid instruction
  always_ff @(posedge clk) begin
    if (instr_i.valid) begin
      payload_q <= ex_d;
    end
  end

  always_comb begin
    ex_o       = payload_q;
    ex_o.valid = valid_q;
  end

endmodule

// ==== logic/reg_file.sv ====
// Flip-flop register file with three read ports and two prioritized write ports
`include "core_config.svh"

module reg_file (
  input  logic                clk,
  input  logic                rst_n,

  // Read port A
  input  core_pkg::reg_addr_t raddr_a_i,
  output core_pkg::word_t     rdata_a_o,

  // Read port B
  input  core_pkg::reg_addr_t raddr_b_i,
  output core_pkg::word_t     rdata_b_o,

  // Read port C, used by multiply-accumulate
  input  core_pkg::reg_addr_t raddr_c_i,
  output core_pkg::word_t     rdata_c_o,

  // Both write ports from the writeback register
  input  core_pkg::wb_entry_t wb_i
);

  import core_pkg::*;

  // Register storage, entry 0 is a constant
  word_t mem [`CORE_NUM_REGS];

  // One-hot write enables per port, no bit for register 0
  logic [`CORE_NUM_REGS-1:1] we_a_dec;
  logic [`CORE_NUM_REGS-1:1] we_b_dec;

  // --------------------
  // Read
  // --------------------
  assign rdata_a_o = mem[raddr_a_i];
  assign rdata_b_o = mem[raddr_b_i];
  assign rdata_c_o = mem[raddr_c_i];

  // --------------------
  // Write decode
  // --------------------
  always_comb begin
    for (int i = 1; i < `CORE_NUM_REGS; i++) begin
      // Enable gates the address match
      we_a_dec[i] = wb_i.we_a && (wb_i.waddr_a == reg_addr_t'(i));
      we_b_dec[i] = wb_i.we_b && (wb_i.waddr_b == reg_addr_t'(i));
    end
  end

  // --------------------
  // Storage
  // --------------------
  for (genvar i = 0; i < `CORE_NUM_REGS; i++) begin : g_regs
    if (i == 0) begin : g_zero
      // Writes to register 0 go nowhere
      assign mem[i] = '0;
    end else begin : g_ff
      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          mem[i] <= '0;
        end else if (we_b_dec[i]) begin
          // Port B wins on a shared address
          mem[i] <= wb_i.wdata_b;
        end else if (we_a_dec[i]) begin
          mem[i] <= wb_i.wdata_a;
        end
      end
    end
  end

endmodule

// ==== tb.f ====
+incdir+logic
logic/core_pkg.sv
logic/reg_file.sv
logic/operand_stage.sv
logic/exec_stage.sv
logic/int_pipeline.sv
verification/tb_int_pipeline.sv

// ==== verification/tb_int_pipeline.sv ====
// Testbench checking the integer pipeline against a register model with a random program
`include "core_config.svh"

module tb_int_pipeline;

  import core_pkg::*;

  // Limit covers 600 instructions plus about 90 bubbles, reset and drain with margin
  localparam int CYCLE_LIMIT = 2000;
  localparam int NUM_INSTR   = 600;

  logic      clk;
  logic      rst_n;
  instr_t    instr_i;
  wb_entry_t commit_o;

  // Architectural model and the expected commit one edge ahead of the check
  word_t     model_regs [`CORE_NUM_REGS];
  wb_entry_t pending_q [$];
  wb_entry_t exp_commit;
  logic      check_en;
  int        valid_issued;
  int        cycle_count;
  logic [31:0] lfsr_state;

  int_pipeline uut (
    .clk      (clk),
    .rst_n    (rst_n),
    .instr_i  (instr_i),
    .commit_o (commit_o)
  );

  always #2 clk = ~clk;

  // --------------------
  // Helpers
  // --------------------
  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] bits;
    logic        b;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      b          = lfsr_state[0];
      lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
      bits       = {bits[30:0], b};
    end
    return bits;
  endfunction

  function automatic word_t sign_extend(input imm_t imm);
    word_t w;
    w = '0;
    w[`CORE_IMM_WIDTH-1:0] = imm;
    if (imm[`CORE_IMM_WIDTH-1]) begin
      w[`CORE_DATA_WIDTH-1:`CORE_IMM_WIDTH] = '1;
    end
    return w;
  endfunction

  // Applies one instruction in program order and returns its expected commit
  function automatic wb_entry_t model_step(input instr_t ins);
    wb_entry_t   e;
    word_t       s1;
    word_t       s2;
    word_t       s3;
    word_t       imm_w;
    logic [63:0] prod;
    e = '0;
    if (ins.valid) begin
      s1      = model_regs[ins.rs1];
      s2      = model_regs[ins.rs2];
      s3      = model_regs[ins.rs3];
      imm_w   = sign_extend(ins.imm);
      e.we_a    = 1'b1;
      e.waddr_a = ins.rd;
      case (ins.op)
        OP_LI:   e.wdata_a = imm_w;
        OP_ADD:  e.wdata_a = s1 + s2;
        OP_SUB:  e.wdata_a = s1 - s2;
        OP_AND:  e.wdata_a = s1 & s2;
        OP_OR:   e.wdata_a = s1 | s2;
        OP_XOR:  e.wdata_a = s1 ^ s2;
        OP_MAC: begin
          prod      = s1 * s2;
          e.wdata_a = prod[31:0] + s3;
        end
        OP_PINC: begin
          e.wdata_a = s1;
          e.we_b    = 1'b1;
          e.waddr_b = ins.rs1;
          e.wdata_b = s1 + imm_w;
        end
        default: e.wdata_a = '0;
      endcase
      model_regs[ins.rd] = e.wdata_a;
      // Second write lands last and wins on rd == rs1
      if (e.we_b) begin
        model_regs[ins.rs1] = e.wdata_b;
      end
      model_regs[0] = '0;
    end
    return e;
  endfunction

  // Address and data only count where the enable is set
  function automatic bit commit_matches(input wb_entry_t e, input wb_entry_t a);
    bit ok;
    ok = (a.we_a === e.we_a) && (a.we_b === e.we_b);
    if (ok && e.we_a) begin
      ok = (a.waddr_a === e.waddr_a) && (a.wdata_a === e.wdata_a);
    end
    if (ok && e.we_b) begin
      ok = (a.waddr_b === e.waddr_b) && (a.wdata_b === e.wdata_b);
    end
    return ok;
  endfunction

  task automatic abort_run();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic stop_with_error(input string msg);
    $display("Error: %s", msg);
    abort_run();
  endtask

  // One field with both values, then the run ends
  task automatic print_mismatch(input string name, input logic [31:0] ev,
                                input logic [31:0] av);
    $display("Mismatch at time %0t: %s expected %h, actual %h", $time, name, ev, av);
    abort_run();
  endtask

  // Names the first field that differs
  task automatic report_mismatch(input wb_entry_t e, input wb_entry_t a);
    if (a.we_a !== e.we_a) begin
      print_mismatch("commit_o.we_a", 32'(e.we_a), 32'(a.we_a));
    end else if (a.we_b !== e.we_b) begin
      print_mismatch("commit_o.we_b", 32'(e.we_b), 32'(a.we_b));
    end else if (e.we_a && a.waddr_a !== e.waddr_a) begin
      print_mismatch("commit_o.waddr_a", 32'(e.waddr_a), 32'(a.waddr_a));
    end else if (e.we_a && a.wdata_a !== e.wdata_a) begin
      print_mismatch("commit_o.wdata_a", e.wdata_a, a.wdata_a);
    end else if (e.we_b && a.waddr_b !== e.waddr_b) begin
      print_mismatch("commit_o.waddr_b", 32'(e.waddr_b), 32'(a.waddr_b));
    end else begin
      print_mismatch("commit_o.wdata_b", e.wdata_b, a.wdata_b);
    end
  endtask

  // Holds one slot from a small delay after the edge until the next edge
  task automatic drive_slot(input instr_t ins);
    instr_i = ins;
    if (ins.valid) begin
      valid_issued++;
    end
    @(posedge clk);
    #1;
  endtask

  // --------------------
  // Checking
  // --------------------
  // Expected entry is ready one edge after acceptance and compared on the next
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      check_en   <= 1'b0;
      exp_commit <= '0;
      pending_q.delete();
      for (int i = 0; i < `CORE_NUM_REGS; i++) begin
        model_regs[i] = '0;
      end
    end else begin
      if (pending_q.size() > 0) begin
        exp_commit <= pending_q.pop_front();
        check_en   <= 1'b1;
      end
      pending_q.push_back(model_step(instr_i));
    end
  end

  commit_check: assert property (@(posedge clk) disable iff (!rst_n)
    check_en |-> commit_matches(exp_commit, commit_o))
    else report_mismatch($sampled(exp_commit), $sampled(commit_o));

  // Timeout
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      stop_with_error($sformatf("Run did not finish within %0d cycles", CYCLE_LIMIT));
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  initial begin
    instr_t ins;
    lfsr_state   = 32'h1bc9dea7;
    clk          = 1'b0;
    rst_n        = 1'b0;
    instr_i      = '0;
    valid_issued = 0;
    cycle_count  = 0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    assert (commit_o.we_a === 1'b0 && commit_o.we_b === 1'b0)
      else report_mismatch('0, commit_o);

    // Reads of never-written registers see zero
    ins       = '0;
    ins.valid = 1'b1;
    ins.op    = OP_MAC;
    ins.rd    = 5'd1;
    ins.rs1   = 5'd2;
    ins.rs2   = 5'd3;
    ins.rs3   = 5'd4;
    drive_slot(ins);

    // Load every pool register including register 0
    for (int r = 0; r < 8; r++) begin
      ins       = '0;
      ins.valid = 1'b1;
      ins.op    = OP_LI;
      ins.rd    = reg_addr_t'(r);
      ins.imm   = imm_t'(rand_bits(`CORE_IMM_WIDTH));
      drive_slot(ins);
    end

    // Random program over registers 0 to 7 with a bubble about one slot in eight
    while (valid_issued < NUM_INSTR) begin
      ins.valid = (rand_bits(3) != 0);
      ins.op    = op_e'(rand_bits(3));
      ins.rd    = reg_addr_t'(rand_bits(3));
      ins.rs1   = reg_addr_t'(rand_bits(3));
      ins.rs2   = reg_addr_t'(rand_bits(3));
      ins.rs3   = reg_addr_t'(rand_bits(3));
      ins.imm   = imm_t'(rand_bits(`CORE_IMM_WIDTH));
      drive_slot(ins);
    end

    // Drain with bubbles so the last commits get compared
    ins = '0;
    repeat (4) drive_slot(ins);

    $display("Everything OK");
    $finish;
  end

endmodule
